// File: verilog/lq_pkg.sv
package lq_pkg;

	localparam int XLEN      = 64;	// Data and address width
	localparam int ROB_IDX_W = 6;	// Reorder buffer index width
	localparam int PRF_IDX_W = 6;	// Physical register tag width

	// Offset operand while it still waits for its producer
	typedef struct packed {
		logic [XLEN-PRF_IDX_W-1:0] unused;
		logic [PRF_IDX_W-1:0]      tag;
	} lq_opb_pend_t;

	// The ready flag next to it says which reading is live
	typedef union packed {
		logic [XLEN-1:0] data;	// Finished offset value
		lq_opb_pend_t    pend;	// Producer tag in the low bits
	} lq_opb_u;

	typedef struct packed {
		logic                 valid;
		logic [XLEN-1:0]      opa;	// Base operand, always finished
		lq_opb_u              opb;
		logic                 opb_ready;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [PRF_IDX_W-1:0] dest_tag;
	} lq_dispatch_t;

	typedef struct packed {
		logic                 valid;
		logic [PRF_IDX_W-1:0] tag;
		logic [XLEN-1:0]      data;
	} cdb_t;

	typedef struct packed {
		logic [XLEN-1:0]      opa;
		logic [XLEN-1:0]      opb;	// Only meaningful once the entry is ready
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [PRF_IDX_W-1:0] dest_tag;
	} lq_slot_t;

	typedef struct packed {
		logic                 valid;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [XLEN-1:0]      addr;
		logic [PRF_IDX_W-1:0] dest_tag;
	} lq_issue_t;

endpackage

// File: verilog/lq_one_entry.sv
module lq_one_entry (
	input  logic                 clock,
	input  logic                 reset,
	input  lq_pkg::lq_dispatch_t dispatch_write,	// Valid bit is the write strobe
	input  logic                 free,
	input  lq_pkg::cdb_t [1:0]   cdb,	// cdb[0] is CDB 1 and wins a tie
	output logic                 in_use,
	output logic                 ready,
	output lq_pkg::lq_slot_t     slot
);

	logic [lq_pkg::XLEN-1:0]      opa_q;
	lq_pkg::lq_opb_u              opb_q;
	logic [lq_pkg::ROB_IDX_W-1:0] rob_idx_q;
	logic [lq_pkg::PRF_IDX_W-1:0] dest_tag_q;

	logic                         write;
	logic                         watching;
	logic [lq_pkg::PRF_IDX_W-1:0] watch_tag;
	logic                         wake_hit;
	logic [lq_pkg::XLEN-1:0]      wake_data;

	assign write = dispatch_write.valid && !free;	// Free wins over a write

	// An incoming load is compared as it is written, a held one while pending
	always_comb begin
		if (write) begin
			watching  = !dispatch_write.opb_ready;
			watch_tag = dispatch_write.opb.pend.tag;
		end else begin
			watching  = in_use && !ready;
			watch_tag = opb_q.pend.tag;
		end
	end

	always_comb begin
		wake_hit  = 1'b0;
		wake_data = '0;
		if (watching && cdb[1].valid && (cdb[1].tag == watch_tag)) begin
			wake_hit  = 1'b1;
			wake_data = cdb[1].data;
		end
		if (watching && cdb[0].valid && (cdb[0].tag == watch_tag)) begin
			wake_hit  = 1'b1;
			wake_data = cdb[0].data;	// CDB 1 overrides CDB 2
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			in_use <= 1'b0;
			ready  <= 1'b0;
		end else if (free) begin
			in_use <= 1'b0;
			ready  <= 1'b0;
		end else if (write) begin
			in_use <= 1'b1;
			ready  <= dispatch_write.opb_ready || wake_hit;
		end else if (wake_hit) begin
			ready  <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (write) begin
			opa_q      <= dispatch_write.opa;
			rob_idx_q  <= dispatch_write.rob_idx;
			dest_tag_q <= dispatch_write.dest_tag;
			if (wake_hit)
				opb_q.data <= wake_data;
			else
				opb_q <= dispatch_write.opb;	// Tag or data, as rename sent it
		end else if (wake_hit) begin
			opb_q.data <= wake_data;	// Tag is replaced by the broadcast value
		end
	end

	assign slot = '{opa: opa_q, opb: opb_q.data, rob_idx: rob_idx_q, dest_tag: dest_tag_q};

	// The bank only frees the entry it presented as ready
	a_free_in_use: assert property (@(posedge clock) disable iff (reset)
		free |-> in_use)
		else $error("free pulsed on an entry that holds no load");

	a_ready_in_use: assert property (@(posedge clock) disable iff (reset)
		ready |-> in_use)
		else $error("entry ready without a load");

endmodule

// File: verilog/lq_bank.sv
module lq_bank #(
	parameter int BANK_DEPTH = 4
) (
	input  logic                 clock,
	input  logic                 reset,
	input  lq_pkg::lq_dispatch_t dispatch,
	input  lq_pkg::cdb_t [1:0]   cdb,
	input  logic                 grant,	// Free the presented entry
	output logic                 ready_any,
	output logic                 full,
	output lq_pkg::lq_slot_t     ready_slot
);

	localparam int IDX_W = $clog2(BANK_DEPTH);

	logic [BANK_DEPTH-1:0]                    in_use;
	logic [BANK_DEPTH-1:0]                    ready;
	logic [BANK_DEPTH-1:0]                    free;
	lq_pkg::lq_slot_t [BANK_DEPTH-1:0]        slots;
	lq_pkg::lq_dispatch_t [BANK_DEPTH-1:0]    entry_write;
	logic [IDX_W-1:0]                         alloc_idx;
	logic [IDX_W-1:0]                         pick_idx;

	// Scan from the top so the lowest index is the one left standing
	always_comb begin
		alloc_idx = '0;
		pick_idx  = '0;
		for (int i = BANK_DEPTH - 1; i >= 0; i--) begin
			if (!in_use[i])
				alloc_idx = IDX_W'(i);
			if (ready[i])
				pick_idx = IDX_W'(i);
		end
	end

	assign full      = &in_use;	// A freed entry shows free only next cycle
	assign ready_any = |ready;
	assign ready_slot = slots[pick_idx];

	always_comb begin
		for (int i = 0; i < BANK_DEPTH; i++) begin
			entry_write[i]       = dispatch;
			entry_write[i].valid = dispatch.valid && !full && (alloc_idx == IDX_W'(i));
			free[i]              = grant && (pick_idx == IDX_W'(i));
		end
	end

	for (genvar i = 0; i < BANK_DEPTH; i++) begin : g_entry
		lq_one_entry u_entry (
			.clock          (clock),
			.reset          (reset),
			.dispatch_write (entry_write[i]),
			.free           (free[i]),
			.cdb            (cdb),
			.in_use         (in_use[i]),
			.ready          (ready[i]),
			.slot           (slots[i])
		);
	end

	// Rename has to honor the full level of this bank
	a_no_dispatch_full: assert property (@(posedge clock) disable iff (reset)
		dispatch.valid |-> !full)
		else $error("load dispatched into a full bank");

endmodule

// File: verilog/lq_issue_select.sv
module lq_issue_select (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       mem_stall,
	input  logic [1:0]                 ready_any,
	input  lq_pkg::lq_slot_t [1:0]     ready_slot,
	output logic [1:0]                 grant,
	output lq_pkg::lq_issue_t          issue
);

	logic                    rr_ptr;	// Bank with priority on a tie
	logic                    win;
	lq_pkg::lq_slot_t        chosen;
	logic [lq_pkg::XLEN-1:0] addr;

	always_comb begin
		grant = 2'b00;
		if (!mem_stall) begin
			if (ready_any[rr_ptr])
				grant[rr_ptr] = 1'b1;
			else if (ready_any[~rr_ptr])
				grant[~rr_ptr] = 1'b1;
		end
	end

	assign win    = grant[1];
	assign chosen = ready_slot[win];
	assign addr   = chosen.opa + chosen.opb;	// Wraps at 64 bits

	// Pointer moves past whichever bank was served
	always_ff @(posedge clock) begin
		if (reset)
			rr_ptr <= 1'b0;
		else if (|grant)
			rr_ptr <= ~win;
	end

	always_ff @(posedge clock) begin
		if (reset)
			issue.valid <= 1'b0;
		else
			issue.valid <= |grant;
		if (|grant) begin
			issue.rob_idx  <= chosen.rob_idx;
			issue.addr     <= addr;
			issue.dest_tag <= chosen.dest_tag;
		end
	end

	a_grant_legal: assert property (@(posedge clock) disable iff (reset)
		$onehot0(grant) && ((grant & ~ready_any) == 2'b00))
		else $error("grant not one-hot or given to a bank with nothing ready");

endmodule

// File: verilog/lq_top.sv
module lq_top #(
	parameter int BANK_DEPTH = 4
) (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        mem_stall,
	input  lq_pkg::lq_dispatch_t [1:0]  dispatch,	// Slot b always fills bank b
	input  lq_pkg::cdb_t [1:0]          cdb,
	output lq_pkg::lq_issue_t           issue,
	output logic [1:0]                  full
);

	logic [1:0]             ready_any;
	lq_pkg::lq_slot_t [1:0] ready_slot;
	logic [1:0]             grant;

	for (genvar b = 0; b < 2; b++) begin : g_bank
		lq_bank #(
			.BANK_DEPTH (BANK_DEPTH)
		) u_bank (
			.clock      (clock),
			.reset      (reset),
			.dispatch   (dispatch[b]),
			.cdb        (cdb),	// Every bank snoops both buses
			.grant      (grant[b]),
			.ready_any  (ready_any[b]),
			.full       (full[b]),
			.ready_slot (ready_slot[b])
		);
	end

	lq_issue_select u_select (
		.clock      (clock),
		.reset      (reset),
		.mem_stall  (mem_stall),
		.ready_any  (ready_any),
		.ready_slot (ready_slot),
		.grant      (grant),
		.issue      (issue)
	);

endmodule

// File: test/lq_tb.sv
module lq_tb;

	localparam int DEPTH = 4;
	localparam int BUDGET_CYCLES = 10 + 30 + 20 + 30 + 40 + 2200;	// Sum of the per-test limits

	logic                       clock;
	logic                       reset;
	logic                       mem_stall;
	lq_pkg::lq_dispatch_t [1:0] dispatch;
	lq_pkg::cdb_t [1:0]         cdb;
	lq_pkg::lq_issue_t          issue;
	logic [1:0]                 full;

	lq_pkg::lq_dispatch_t [1:0] next_disp;	// Applied at the next rising edge
	lq_pkg::cdb_t [1:0]         next_cdb;
	logic                       next_stall;
	logic                       stall_seen;	// Stall level of the cycle that just ended

	// Reference model, indexed by rob index
	logic        live [64];
	logic        known [64];
	logic [63:0] m_opa [64];
	logic [63:0] m_opb [64];
	logic [5:0]  m_tag [64];
	logic [5:0]  m_dest [64];
	int          m_bank [64];
	int          disp_cyc [64];
	int          issue_cyc [64];
	logic [63:0] issue_addr [64];
	logic        waiting_tag [64];	// Producers not yet broadcast
	int          occ [2];	// Includes loads still in flight to the bank
	int          live_count;
	int          cycle_count;
	int          errors;
	int          tests_passed;
	int          tests_failed;

	lq_top #(
		.BANK_DEPTH (DEPTH)
	) uut (
		.clock     (clock),
		.reset     (reset),
		.mem_stall (mem_stall),
		.dispatch  (dispatch),
		.cdb       (cdb),
		.issue     (issue),
		.full      (full)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	initial begin
		#(BUDGET_CYCLES * 40 + 4000);
		$display("Watchdog expired: the tests did not finish within their cycle budget");
		$display("Test failures found");
		$finish;
	end

	task queue_load(input int slot, input bit rdy, input logic [5:0] tag, output int rob);
		int start;
		int r;
		start = $urandom % 64;
		rob = -1;
		for (int i = 0; i < 64; i++) begin
			r = (start + i) % 64;
			if (rob < 0 && !live[r])
				rob = r;
		end
		next_disp[slot].valid     = 1'b1;
		next_disp[slot].opa       = {$urandom, $urandom};
		next_disp[slot].opb.data  = {$urandom, $urandom};
		next_disp[slot].opb_ready = rdy;
		next_disp[slot].rob_idx   = rob[5:0];
		next_disp[slot].dest_tag  = $urandom % 64;
		if (!rdy)
			next_disp[slot].opb.pend.tag = tag;	// Low bits carry the producer tag
		live[rob]     = 1'b1;
		known[rob]    = rdy;
		m_opa[rob]    = next_disp[slot].opa;
		m_opb[rob]    = next_disp[slot].opb.data;
		m_tag[rob]    = tag;
		m_dest[rob]   = next_disp[slot].dest_tag;
		m_bank[rob]   = slot;
		disp_cyc[rob] = cycle_count + 1;
		occ[slot]++;
		live_count++;
		if (!rdy)
			waiting_tag[tag] = 1'b1;
	endtask

	task send_broadcast(input int bus, input logic [5:0] tag, input logic [63:0] data);
		next_cdb[bus] = '{valid: 1'b1, tag: tag, data: data};
		waiting_tag[tag] = 1'b0;
	endtask

	task find_waiting_tag(output logic [5:0] tag, output bit found);
		int start;
		start = $urandom % 64;
		found = 1'b0;
		tag = '0;
		for (int i = 0; i < 64; i++) begin
			if (!found && waiting_tag[(start + i) % 64]) begin
				found = 1'b1;
				tag = (start + i) % 64;
			end
		end
	endtask

	task observe;
		int r;
		assert (!$isunknown(issue.valid))
		else begin
			$display("FAIL %0t: issue.valid is unknown", $time);
			errors++;
		end
		if (issue.valid === 1'b1) begin
			r = issue.rob_idx;
			assert (!stall_seen)
			else begin
				$display("FAIL %0t: issue after a stalled cycle, rob %0d", $time, r);
				errors++;
			end
			assert (live[r])
			else begin
				$display("FAIL %0t: rob %0d issued but not held", $time, r);
				errors++;
			end
			if (live[r]) begin
				assert (known[r])
				else begin
					$display("FAIL %0t: rob %0d issued before its tag was broadcast", $time, r);
					errors++;
				end
				assert (issue.addr === m_opa[r] + m_opb[r] && issue.dest_tag === m_dest[r])
				else begin
					$display("FAIL %0t: rob %0d addr %h dest %0d, expected %h dest %0d",
						$time, r, issue.addr, issue.dest_tag, m_opa[r] + m_opb[r], m_dest[r]);
					errors++;
				end
				live[r] = 1'b0;
				occ[m_bank[r]]--;
				live_count--;
				issue_cyc[r]  = cycle_count;
				issue_addr[r] = issue.addr;
			end
		end
		// The load issued at this edge has already left its entry
		for (int b = 0; b < 2; b++)
			assert (full[b] === ((occ[b] - dispatch[b].valid) == DEPTH))
			else begin
				$display("FAIL %0t: bank %0d full is %b", $time, b, full[b]);
				errors++;
			end
	endtask

	task tick;
		// Wake model loads with the buses about to be driven, CDB 1 first
		for (int r = 0; r < 64; r++) begin
			if (live[r] && !known[r]) begin
				if (next_cdb[0].valid && next_cdb[0].tag == m_tag[r]) begin
					m_opb[r] = next_cdb[0].data;
					known[r] = 1'b1;
				end else if (next_cdb[1].valid && next_cdb[1].tag == m_tag[r]) begin
					m_opb[r] = next_cdb[1].data;
					known[r] = 1'b1;
				end
			end
		end
		@(posedge clock);
		stall_seen = mem_stall;
		dispatch  <= next_disp;
		cdb       <= next_cdb;
		mem_stall <= next_stall;
		next_disp = '0;
		next_cdb  = '0;
		cycle_count++;
		@(negedge clock);
		observe();
	endtask

	task apply_reset;
		@(posedge clock);
		reset     <= 1'b1;
		dispatch  <= '0;
		cdb       <= '0;
		mem_stall <= 1'b0;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		next_disp  = '0;
		next_cdb   = '0;
		next_stall = 1'b0;
		stall_seen = 1'b0;
		for (int i = 0; i < 64; i++) begin
			live[i] = 1'b0;
			waiting_tag[i] = 1'b0;
		end
		occ[0] = 0;
		occ[1] = 0;
		live_count = 0;
		assert (issue.valid === 1'b0 && full === 2'b00)
		else begin
			$display("FAIL %0t: outputs not cleared by reset", $time);
			errors++;
		end
	endtask

	task drain(input int max_cycles);
		int n;
		logic [5:0] t;
		bit found;
		n = 0;
		next_stall = 1'b0;
		while (live_count > 0 && n < max_cycles) begin
			for (int bus = 0; bus < 2; bus++) begin
				find_waiting_tag(t, found);
				if (found)
					send_broadcast(bus, t, {$urandom, $urandom});
			end
			tick();
			n++;
		end
		assert (live_count == 0)
		else begin
			$display("Queue did not drain: %0d loads still held at time %0t", live_count, $time);
			errors++;
		end
	endtask

	task finish_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			$display("test %s: pass", name);
			tests_passed++;
		end else begin
			$display("test %s: fail with %0d errors", name, errors - errors_before);
			tests_failed++;
		end
	endtask

	task direct_issue;
		int e0;
		int r;
		e0 = errors;
		queue_load(0, 1'b1, '0, r);
		drain(10);
		assert (issue_cyc[r] == disp_cyc[r] + 2)
		else begin
			$display("FAIL %0t: direct issue took %0d cycles", $time, issue_cyc[r] - disp_cyc[r]);
			errors++;
		end
		finish_test("direct_issue", e0);
	endtask

	task wakeup;
		int e0;
		int r0;
		int r1;
		logic [63:0] d0;
		e0 = errors;
		d0 = {$urandom, $urandom};
		queue_load(0, 1'b0, 6'd17, r0);
		repeat (3) tick();
		assert (live[r0])
		else begin
			$display("FAIL %0t: pending load left the queue early", $time);
			errors++;
		end
		send_broadcast(0, 6'd17, d0);	// Same tag on both buses
		send_broadcast(1, 6'd17, ~d0);
		tick();
		queue_load(1, 1'b0, 6'd42, r1);
		send_broadcast(1, 6'd42, {$urandom, $urandom});	// Wakes in its dispatch cycle
		drain(10);
		assert (issue_addr[r0] === m_opa[r0] + d0)
		else begin
			$display("FAIL %0t: wakeup addr %h did not use CDB 1 data", $time, issue_addr[r0]);
			errors++;
		end
		finish_test("wakeup", e0);
	endtask

	task round_robin;
		int e0;
		int r0;
		int r1;
		e0 = errors;
		apply_reset();
		queue_load(0, 1'b1, '0, r0);
		queue_load(1, 1'b1, '0, r1);
		drain(10);
		assert (issue_cyc[r0] == disp_cyc[r0] + 2 && issue_cyc[r1] == issue_cyc[r0] + 1)
		else begin
			$display("FAIL %0t: bank order wrong, issued at %0d and %0d",
				$time, issue_cyc[r0], issue_cyc[r1]);
			errors++;
		end
		finish_test("round_robin", e0);
	endtask

	task stall;
		int e0;
		int r;
		e0 = errors;
		next_stall = 1'b1;
		repeat (2) begin
			queue_load(0, 1'b1, '0, r);
			queue_load(1, 1'b1, '0, r);
			tick();
		end
		repeat (4) tick();
		assert (live_count == 4)
		else begin
			$display("FAIL %0t: %0d loads held during stall, expected 4", $time, live_count);
			errors++;
		end
		drain(20);
		finish_test("stall", e0);
	endtask

	task full_bank;
		int e0;
		int r;
		e0 = errors;
		for (int i = 0; i < 4; i++) begin
			queue_load(0, 1'b0, 6'(20 + i), r);
			tick();
		end
		tick();
		assert (full[0] === 1'b1)
		else begin
			$display("FAIL %0t: bank 0 not full with four pending loads", $time);
			errors++;
		end
		drain(20);
		assert (full[0] === 1'b0)
		else begin
			$display("FAIL %0t: bank 0 still full after draining", $time);
			errors++;
		end
		finish_test("full_bank", e0);
	endtask

	task random_run;
		int e0;
		int r;
		logic [5:0] t;
		bit found;
		e0 = errors;
		repeat (2000) begin
			next_stall = ($urandom % 10 == 0);
			for (int s = 0; s < 2; s++)
				if (occ[s] < DEPTH && $urandom % 2 == 1)
					queue_load(s, $urandom % 2, $urandom % 64, r);
			for (int bus = 0; bus < 2; bus++) begin
				if ($urandom % 100 < 40) begin
					if (bus == 1 && next_cdb[0].valid && $urandom % 4 == 0) begin
						send_broadcast(1, next_cdb[0].tag, {$urandom, $urandom});
					end else begin
						find_waiting_tag(t, found);
						if (found)
							send_broadcast(bus, t, {$urandom, $urandom});
					end
				end
			end
			tick();
		end
		drain(200);
		finish_test("random_run", e0);
	endtask

	initial begin
		void'($urandom(74));
		reset       = 1'b1;
		mem_stall   = 1'b0;
		dispatch    = '0;
		cdb         = '0;
		errors      = 0;
		cycle_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		apply_reset();
		direct_issue();
		wakeup();
		round_robin();
		stall();
		full_bank();
		random_run();
		$display("%0d tests passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: sim.f
verilog/lq_pkg.sv
verilog/lq_one_entry.sv
verilog/lq_bank.sv
verilog/lq_issue_select.sv
verilog/lq_top.sv
test/lq_tb.sv

// File: Bender.yml
package:
  name: lq

sources:
  - verilog/lq_pkg.sv
  - verilog/lq_one_entry.sv
  - verilog/lq_bank.sv
  - verilog/lq_issue_select.sv
  - verilog/lq_top.sv
  - target: simulation
    files:
      - test/lq_tb.sv
